//--- design/serial_alu.sv
`timescale 1ns/1ps
`default_nettype none

module serial_alu
   import serial_core_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     i_arst_n,
   input  wire logic     i_en,
   input  wire logic     i_first,
   input  wire alu_op_e  i_op,
   input  wire logic     i_rs1_bit,
   input  wire logic     i_op_b_bit,
   output logic          o_bit,
   output logic          o_cmp_eq
);

   logic is_sub;
   logic op_b;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic carry_out;
   logic eq_in;
   logic eq_q;

   // Subtract as a + ~b + 1
   assign is_sub    = (i_op == ALU_SUB);
   assign op_b      = is_sub ? ~i_op_b_bit : i_op_b_bit;
   assign carry_in  = i_first ? is_sub : carry_q;
   assign sum       = i_rs1_bit ^ op_b ^ carry_in;
   assign carry_out = (i_rs1_bit & op_b) | (carry_in & (i_rs1_bit ^ op_b));

   assign eq_in = i_first ? 1'b1 : eq_q;

   always_comb begin
      case (i_op)
         ALU_AND: o_bit = i_rs1_bit & i_op_b_bit;
         ALU_OR:  o_bit = i_rs1_bit | i_op_b_bit;
         ALU_XOR: o_bit = i_rs1_bit ^ i_op_b_bit;
         default: o_bit = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
      end else if (i_en) begin
         carry_q <= carry_out;
         eq_q    <= eq_in & (i_rs1_bit == i_op_b_bit);
      end
   end

   assign o_cmp_eq = eq_q;

endmodule

`default_nettype wire

//--- design/serial_core_params.svh
`ifndef SERIAL_CORE_PARAMS_SVH
`define SERIAL_CORE_PARAMS_SVH

// Address of the first instruction fetch
`define CORE_RESET_PC 32'h0000_0000

// Data word width
`define CORE_XLEN 32

// Bit counter width for a pass of 2**CORE_CNT_W bits
`define CORE_CNT_W 5

`endif

//--- design/serial_core_pkg.sv
`default_nettype none

`include "serial_core_params.svh"

package serial_core_pkg;

   typedef logic [`CORE_XLEN-1:0]  word_t;
   typedef logic [4:0]             reg_addr_t;
   typedef logic [`CORE_CNT_W-1:0] bit_cnt_t;

   typedef enum logic [1:0] {FETCH, RUN, MEM, LOAD_WB} core_state_e;

   typedef enum logic [1:0] {RD_ALU, RD_LINK, RD_IMM, RD_MEM} rd_src_e;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

   // Decoded instruction held stable for the whole instruction
   typedef struct packed {
      reg_addr_t rd_addr;
      reg_addr_t rs1_addr;
      reg_addr_t rs2_addr;
      logic      rd_wen;
      alu_op_e   alu_op;
      logic      op_b_imm;
      rd_src_e   rd_src;
      logic      is_branch;
      logic      branch_ne;
      logic      is_jal;
      logic      is_load;
      logic      is_store;
   } dec_ctrl_t;

   typedef struct packed {
      word_t adr;
      word_t dat;
      logic  we;
      logic  cyc;
   } dbus_req_t;

endpackage

`default_nettype wire

//--- design/serial_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module serial_core_top
   import serial_core_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   i_arst_n,
   output word_t       o_ibus_adr,
   output logic        o_ibus_cyc,
   input  wire word_t  i_ibus_rdt,
   input  wire logic   i_ibus_ack,
   output word_t       o_dbus_adr,
   output word_t       o_dbus_dat,
   output logic        o_dbus_we,
   output logic        o_dbus_cyc,
   input  wire word_t  i_dbus_rdt,
   input  wire logic   i_dbus_ack
);

   core_state_e state;
   bit_cnt_t    cnt;
   dec_ctrl_t   ctrl;
   dbus_req_t   dbus;
   logic        cnt_en, run_first, cnt_done, pass_end, fetch_go;
   logic        first_bit, rf_load, ibus_ack, dbus_ack;
   logic        imm_bit, rs1_bit, rs2_bit, op_b_bit;
   logic        alu_bit, cmp_eq, link_bit, mem_bit, rd_bit;

   // Acks outside a bus cycle are dropped
   assign ibus_ack  = i_ibus_ack & o_ibus_cyc;
   assign dbus_ack  = i_dbus_ack & dbus.cyc;
   assign first_bit = (cnt == '0);
   assign rf_load   = (state == RUN) & first_bit;
   assign op_b_bit  = ctrl.op_b_imm ? imm_bit : rs2_bit;

   always_comb begin
      case (ctrl.rd_src)
         RD_LINK: rd_bit = link_bit;
         RD_IMM:  rd_bit = imm_bit;
         RD_MEM:  rd_bit = mem_bit;
         default: rd_bit = alu_bit;
      endcase
   end

   assign o_dbus_adr = dbus.adr;
   assign o_dbus_dat = dbus.dat;
   assign o_dbus_we  = dbus.we;
   assign o_dbus_cyc = dbus.cyc;

   serial_state u_state (
      .clk(clk), .i_arst_n(i_arst_n), .i_ibus_ack(ibus_ack), .i_dbus_ack(dbus_ack),
      .i_ctrl(ctrl), .o_state(state), .o_cnt(cnt), .o_cnt_en(cnt_en),
      .o_run_first(run_first), .o_cnt_done(cnt_done), .o_pass_end(pass_end),
      .o_fetch_go(fetch_go));

   serial_decode u_decode (
      .clk(clk), .i_arst_n(i_arst_n), .i_ibus_rdt(i_ibus_rdt), .i_ibus_ack(ibus_ack),
      .i_cnt(cnt), .o_ctrl(ctrl), .o_imm_bit(imm_bit));

   serial_regfile u_regfile (
      .clk(clk), .i_arst_n(i_arst_n), .i_ctrl(ctrl), .i_load(rf_load), .i_shift(cnt_en),
      .i_rd_bit(rd_bit), .i_wr(pass_end), .o_rs1_bit(rs1_bit), .o_rs2_bit(rs2_bit));

   // ALU holds its flags outside the first pass
   serial_alu u_alu (
      .clk(clk), .i_arst_n(i_arst_n), .i_en(cnt_en & run_first), .i_first(first_bit),
      .i_op(ctrl.alu_op), .i_rs1_bit(rs1_bit), .i_op_b_bit(op_b_bit), .o_bit(alu_bit),
      .o_cmp_eq(cmp_eq));

   serial_ctrl u_ctrl (
      .clk(clk), .i_arst_n(i_arst_n), .i_cnt_en(cnt_en), .i_first(first_bit),
      .i_cnt_done(cnt_done), .i_run_first(run_first), .i_ctrl(ctrl), .i_imm_bit(imm_bit),
      .i_cmp_eq(cmp_eq), .i_fetch_go(fetch_go), .i_ibus_ack(ibus_ack),
      .o_link_bit(link_bit), .o_ibus_adr(o_ibus_adr), .o_ibus_cyc(o_ibus_cyc));

   serial_mem_if u_mem_if (
      .clk(clk), .i_arst_n(i_arst_n), .i_cnt_en(cnt_en), .i_run_first(run_first),
      .i_cnt_done(cnt_done), .i_ctrl(ctrl), .i_addr_bit(alu_bit), .i_rs2_bit(rs2_bit),
      .i_dbus_rdt(i_dbus_rdt), .i_dbus_ack(dbus_ack), .o_dbus(dbus), .o_mem_bit(mem_bit));

endmodule

`default_nettype wire

//--- design/serial_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "serial_core_params.svh"

module serial_ctrl
   import serial_core_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       i_arst_n,
   input  wire logic       i_cnt_en,
   input  wire logic       i_first,
   input  wire logic       i_cnt_done,
   input  wire logic       i_run_first,
   input  wire dec_ctrl_t  i_ctrl,
   input  wire logic       i_imm_bit,
   input  wire logic       i_cmp_eq,
   input  wire logic       i_fetch_go,
   input  wire logic       i_ibus_ack,
   output logic            o_link_bit,
   output word_t           o_ibus_adr,
   output logic            o_ibus_cyc
);

   word_t      pc_q;
   word_t      pc_imm_q;
   logic [2:0] four_q;
   logic       shift_en;
   logic       c4_in;
   logic       c4_q;
   logic       cimm_in;
   logic       cimm_q;
   logic       sum4;
   logic       sum_imm;
   logic       take;

   assign shift_en = i_cnt_en & i_run_first;

   // PC shifts out LSB first and PC+4 shifts in at the top
   assign c4_in   = i_first ? 1'b0 : c4_q;
   assign sum4    = pc_q[0] ^ four_q[0] ^ c4_in;
   assign cimm_in = i_first ? 1'b0 : cimm_q;
   assign sum_imm = pc_q[0] ^ i_imm_bit ^ cimm_in;

   assign o_link_bit = sum4;

   assign take       = i_ctrl.is_jal | (i_ctrl.is_branch & (i_cmp_eq ^ i_ctrl.branch_ne));
   assign o_ibus_adr = take ? pc_imm_q : pc_q;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q       <= `CORE_RESET_PC;
         c4_q       <= 1'b0;
         cimm_q     <= 1'b0;
         four_q     <= 3'b100;
         o_ibus_cyc <= 1'b1;
      end else begin
         if (shift_en) begin
            pc_q   <= {sum4, pc_q[31:1]};
            c4_q   <= (pc_q[0] & four_q[0]) | (c4_in & (pc_q[0] ^ four_q[0]));
            cimm_q <= (pc_q[0] & i_imm_bit) | (cimm_in & (pc_q[0] ^ i_imm_bit));
            // Marker lands on bit 2 of the next pass
            four_q <= i_cnt_done ? 3'b100 : {1'b0, four_q[2:1]};
         end else if (i_ibus_ack && take) begin
            pc_q <= pc_imm_q;
         end
         if (i_fetch_go) begin
            o_ibus_cyc <= 1'b1;
         end else if (i_ibus_ack) begin
            o_ibus_cyc <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (shift_en) begin
         pc_imm_q <= {sum_imm, pc_imm_q[31:1]};
      end
   end

endmodule

`default_nettype wire

//--- design/serial_decode.sv
`timescale 1ns/1ps
`default_nettype none

module serial_decode
   import serial_core_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      i_arst_n,
   input  wire word_t     i_ibus_rdt,
   input  wire logic      i_ibus_ack,
   input  wire bit_cnt_t  i_cnt,
   output dec_ctrl_t      o_ctrl,
   output logic           o_imm_bit
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   word_t      instr_q;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       wr;
   word_t      imm;

   assign opcode = instr_q[6:0];
   assign funct3 = instr_q[14:12];
   assign funct7 = instr_q[31:25];

   // Zero decodes as an unknown opcode, so reset leaves a no-op
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         instr_q <= '0;
      end else if (i_ibus_ack) begin
         instr_q <= i_ibus_rdt;
      end
   end

   always_comb begin
      o_ctrl          = '0;
      o_ctrl.rd_addr  = instr_q[11:7];
      o_ctrl.rs1_addr = instr_q[19:15];
      o_ctrl.rs2_addr = instr_q[24:20];
      o_ctrl.alu_op   = ALU_ADD;
      o_ctrl.rd_src   = RD_ALU;
      wr              = 1'b0;
      case (opcode)
         OPC_OP: begin
            wr = (funct7 == 7'b0000000);
            case (funct3)
               3'b000: begin
                  wr = (funct7 == 7'b0000000) | (funct7 == 7'b0100000);
                  o_ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
               end
               3'b111:  o_ctrl.alu_op = ALU_AND;
               3'b110:  o_ctrl.alu_op = ALU_OR;
               3'b100:  o_ctrl.alu_op = ALU_XOR;
               default: wr = 1'b0;
            endcase
         end
         OPC_OP_IMM: begin
            o_ctrl.op_b_imm = 1'b1;
            wr = 1'b1;
            case (funct3)
               3'b000:  o_ctrl.alu_op = ALU_ADD;
               3'b111:  o_ctrl.alu_op = ALU_AND;
               3'b110:  o_ctrl.alu_op = ALU_OR;
               3'b100:  o_ctrl.alu_op = ALU_XOR;
               default: wr = 1'b0;
            endcase
         end
         OPC_LUI: begin
            wr = 1'b1;
            o_ctrl.rd_src = RD_IMM;
         end
         OPC_JAL: begin
            wr = 1'b1;
            o_ctrl.rd_src = RD_LINK;
            o_ctrl.is_jal = 1'b1;
         end
         OPC_BRANCH: begin
            o_ctrl.is_branch = (funct3 == 3'b000) | (funct3 == 3'b001);
            o_ctrl.branch_ne = funct3[0];
         end
         OPC_LOAD: begin
            wr = (funct3 == 3'b010);
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd_src   = RD_MEM;
            o_ctrl.is_load  = (funct3 == 3'b010);
         end
         OPC_STORE: begin
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.is_store = (funct3 == 3'b010);
         end
         default: wr = 1'b0;
      endcase
      // x0 is never written
      o_ctrl.rd_wen = wr & (instr_q[11:7] != 5'd0);
   end

   always_comb begin
      case (opcode)
         OPC_STORE:  imm = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
         OPC_BRANCH: imm = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                            instr_q[30:25], instr_q[11:8], 1'b0};
         OPC_LUI:    imm = {instr_q[31:12], 12'b0};
         OPC_JAL:    imm = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                            instr_q[20], instr_q[30:21], 1'b0};
         default:    imm = {{20{instr_q[31]}}, instr_q[31:20]};
      endcase
   end

   assign o_imm_bit = imm[i_cnt];

endmodule

`default_nettype wire

//--- design/serial_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

module serial_mem_if
   import serial_core_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       i_arst_n,
   input  wire logic       i_cnt_en,
   input  wire logic       i_run_first,
   input  wire logic       i_cnt_done,
   input  wire dec_ctrl_t  i_ctrl,
   input  wire logic       i_addr_bit,
   input  wire logic       i_rs2_bit,
   input  wire word_t      i_dbus_rdt,
   input  wire logic       i_dbus_ack,
   output dbus_req_t       o_dbus,
   output logic            o_mem_bit
);

   word_t adr_q;
   word_t dat_q;
   word_t rdt_q;
   logic  cyc_q;
   logic  mem_op;

   assign mem_op = i_ctrl.is_load | i_ctrl.is_store;

   // Word accesses only
   assign o_dbus.adr = {adr_q[31:2], 2'b00};
   assign o_dbus.dat = dat_q;
   assign o_dbus.we  = i_ctrl.is_store;
   assign o_dbus.cyc = cyc_q;

   assign o_mem_bit = rdt_q[0];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cyc_q <= 1'b0;
      end else if (i_cnt_en && i_run_first && i_cnt_done && mem_op) begin
         cyc_q <= 1'b1;
      end else if (i_dbus_ack) begin
         cyc_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en && i_run_first) begin
         adr_q <= {i_addr_bit, adr_q[31:1]};
         dat_q <= {i_rs2_bit, dat_q[31:1]};
      end
      // Read word is shifted out during the write-back pass
      if (i_dbus_ack && i_ctrl.is_load) begin
         rdt_q <= i_dbus_rdt;
      end else if (i_cnt_en && !i_run_first) begin
         rdt_q <= rdt_q >> 1;
      end
   end

endmodule

`default_nettype wire

//--- design/serial_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module serial_regfile
   import serial_core_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       i_arst_n,
   input  wire dec_ctrl_t  i_ctrl,
   input  wire logic       i_load,
   input  wire logic       i_shift,
   input  wire logic       i_rd_bit,
   input  wire logic       i_wr,
   output logic            o_rs1_bit,
   output logic            o_rs2_bit
);

   word_t regs [0:31];
   word_t rs1_q;
   word_t rs2_q;
   word_t rd_q;
   word_t rs1_word;
   word_t rs2_word;
   word_t rd_word;

   // Array read bypasses the shifter on the first bit
   assign rs1_word = !i_load ? rs1_q :
                     (i_ctrl.rs1_addr == 5'd0) ? '0 : regs[i_ctrl.rs1_addr];
   assign rs2_word = !i_load ? rs2_q :
                     (i_ctrl.rs2_addr == 5'd0) ? '0 : regs[i_ctrl.rs2_addr];

   assign o_rs1_bit = rs1_word[0];
   assign o_rs2_bit = rs2_word[0];

   // Includes the bit arriving in the write cycle
   assign rd_word = {i_rd_bit, rd_q[31:1]};

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rs1_q <= '0;
         rs2_q <= '0;
         rd_q  <= '0;
      end else if (i_shift) begin
         rs1_q <= rs1_word >> 1;
         rs2_q <= rs2_word >> 1;
         rd_q  <= rd_word;
      end
   end

   always_ff @(posedge clk) begin
      if (i_wr && i_ctrl.rd_wen) begin
         regs[i_ctrl.rd_addr] <= rd_word;
      end
   end

endmodule

`default_nettype wire

//--- design/serial_state.sv
`timescale 1ns/1ps
`default_nettype none

module serial_state
   import serial_core_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       i_arst_n,
   input  wire logic       i_ibus_ack,
   input  wire logic       i_dbus_ack,
   input  wire dec_ctrl_t  i_ctrl,
   output core_state_e     o_state,
   output bit_cnt_t        o_cnt,
   output logic            o_cnt_en,
   output logic            o_run_first,
   output logic            o_cnt_done,
   output logic            o_pass_end,
   output logic            o_fetch_go
);

   core_state_e state_q;
   core_state_e state_d;
   bit_cnt_t    cnt_q;
   logic        last_bit;
   logic        mem_op;

   assign mem_op      = i_ctrl.is_load | i_ctrl.is_store;
   assign last_bit    = (cnt_q == '1);
   assign o_state     = state_q;
   assign o_cnt       = cnt_q;
   assign o_cnt_en    = (state_q == RUN) | (state_q == LOAD_WB);
   assign o_run_first = (state_q == RUN);
   assign o_cnt_done  = o_cnt_en & last_bit;

   // Last bit of the instruction and the register write strobe
   assign o_pass_end = o_cnt_done & (((state_q == RUN) & !mem_op) | (state_q == LOAD_WB));

   // A store finishes at the data bus ack
   assign o_fetch_go = o_pass_end | ((state_q == MEM) & i_dbus_ack & i_ctrl.is_store);

   always_comb begin
      state_d = state_q;
      case (state_q)
         FETCH:   if (i_ibus_ack) state_d = RUN;
         RUN:     if (last_bit) state_d = mem_op ? MEM : FETCH;
         MEM:     if (i_dbus_ack) state_d = i_ctrl.is_load ? LOAD_WB : FETCH;
         LOAD_WB: if (last_bit) state_d = FETCH;
         default: state_d = FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= FETCH;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         // Wraps back to zero after bit 31
         if (o_cnt_en) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/serial_core_pkg.sv
design/serial_state.sv
design/serial_decode.sv
design/serial_regfile.sv
design/serial_alu.sv
design/serial_ctrl.sv
design/serial_mem_if.sv
design/serial_core_top.sv
tb/tb_serial_core.sv

//--- tb/core_input.hex
// One 32-bit hex word per entry. @00 program (word = PC/4), @40 data memory from 0x400,
// @50 store count then address/data pairs, @70 count then fetch addresses after branches
@00
40000513 12300093 faa00113   // addi x10,x0,0x400  addi x1,x0,0x123  addi x2,x0,-86
002081b3 40208233 0020f2b3   // add x3  sub x4  and x5 from x1,x2
0020e333 0020c3b3            // or x6  xor x7
0f00f413 50516493 fff0c593   // andi x8,x1,0xf0  ori x9,x2,0x505  xori x11,x1,-1
abcde637                     // lui x12,0xabcde
00152023 00352223 00452423 00552623 00652823   // sw x1 x3 x4 x5 x6 at 0..16(x10)
00752a23 00852c23 00952e23 02b52023 02c52223   // sw x7 x8 x9 x11 x12 at 20..36(x10)
05508013 02052423            // addi x0,x1,0x55  sw x0,40(x10)
03852683 7ff68713 02e52623   // lw x13,56(x10)  addi x14,x13,0x7ff  sw x14,44(x10)
00108463 02252823            // 0x6c beq x1,x1,+8 taken  skipped sw
00208463                     // 0x74 beq x1,x2,+8 not taken
00209663 02252823 02252823   // 0x78 bne x1,x2,+12 taken  two skipped sw
fe1098e3                     // 0x84 bne x1,x1,-16 not taken
00c007ef 02252823 02252823   // 0x88 jal x15,+12  two skipped sw
02f52823 0000006f            // 0x94 sw x15,48(x10)  0x98 jal x0,0
@40
0bad0400 0bad0404 0bad0408 0bad040c
0bad0410 0bad0414 0bad0418 0bad041c
0bad0420 0bad0424 0bad0428 0bad042c
0bad0430 0bad0434 13572468 0bad043c
@50
0000000d
00000400 00000123 00000404 000000cd   // addi  add
00000408 00000179 0000040c 00000122   // sub  and
00000410 ffffffab 00000414 fffffe89   // or  xor
00000418 00000020 0000041c ffffffaf   // andi  ori
00000420 fffffedc 00000424 abcde000   // xori  lui
00000428 00000000 0000042c 13572c67   // x0  lw plus 0x7ff
00000430 0000008c                     // jal link
@70
00000005
00000074 00000078 00000084 00000088 00000094

//--- tb/tb_serial_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "serial_core_params.svh"

module tb_serial_core
   import serial_core_pkg::*;
();

   localparam int    IMEM_BYTES   = 256;
   localparam word_t DMEM_BASE    = 32'h0000_0400;
   localparam int    DMEM_WORDS   = 16;
   localparam int    DATA_IDX     = 'h40;
   localparam int    STORE_IDX    = 'h50;
   localparam int    FETCH_IDX    = 'h70;
   localparam int    REQ_TIMEOUT  = 100;
   localparam int    MAX_REQUESTS = 300;

   logic   clk;
   logic   arst_n;
   word_t  ibus_adr;
   logic   ibus_cyc;
   word_t  ibus_rdt;
   logic   ibus_ack;
   word_t  dbus_adr;
   word_t  dbus_dat;
   logic   dbus_we;
   logic   dbus_cyc;
   word_t  dbus_rdt;
   logic   dbus_ack;

   word_t  input_words [0:127];
   word_t  dmem [0:DMEM_WORDS-1];
   integer seed;
   int     store_count;
   int     store_idx;
   int     fetch_count;
   int     fetch_idx;
   int     data_count;
   int     requests;
   logic   after_jump;
   logic [6:0] last_opcode;

   serial_core_top uut (
      .clk(clk), .i_arst_n(arst_n),
      .o_ibus_adr(ibus_adr), .o_ibus_cyc(ibus_cyc), .i_ibus_rdt(ibus_rdt), .i_ibus_ack(ibus_ack),
      .o_dbus_adr(dbus_adr), .o_dbus_dat(dbus_dat), .o_dbus_we(dbus_we), .o_dbus_cyc(dbus_cyc),
      .i_dbus_rdt(dbus_rdt), .i_dbus_ack(dbus_ack));

   always #10 clk = ~clk;

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic value_mismatch(input string name, input word_t got, input word_t exp);
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
   endtask

   task automatic run_error(input string msg);
      $display("ERROR: %s", msg);
      abort_run();
   endtask

   task automatic load_input();
      int i;
      for (i = 0; i < 128; i++) begin
         input_words[i] = '0;
      end
      $readmemh("tb/core_input.hex", input_words);
      for (i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = input_words[DATA_IDX + i];
      end
      store_count = input_words[STORE_IDX];
      fetch_count = input_words[FETCH_IDX];
      assert (store_count > 0) else run_error("the input file holds no store records");
   endtask

   task automatic wait_for_request();
      int waited;
      waited = 0;
      while (ibus_cyc !== 1'b1 && dbus_cyc !== 1'b1) begin
         assert (waited < REQ_TIMEOUT)
            else run_error("timed out waiting for an instruction or data bus request");
         @(negedge clk);
         waited++;
      end
      assert (!(ibus_cyc === 1'b1 && dbus_cyc === 1'b1))
         else run_error("instruction and data bus requests are active together");
   endtask

   task automatic serve_fetch();
      word_t adr;
      word_t exp;
      word_t instr;
      int    delay;
      adr = ibus_adr;
      if (after_jump) begin
         assert (fetch_idx < fetch_count) else run_error("more branch targets than listed");
         exp = input_words[FETCH_IDX + 1 + fetch_idx];
         assert (adr === exp) else value_mismatch("o_ibus_adr", adr, exp);
         fetch_idx++;
      end
      assert (adr < IMEM_BYTES && adr[1:0] == 2'b00)
         else run_error("instruction fetch outside the program memory");
      instr = input_words[adr >> 2];
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
         @(negedge clk);
         assert (ibus_cyc === 1'b1 && ibus_adr === adr)
            else run_error("instruction request dropped or changed before its ack");
      end
      ibus_rdt = instr;
      ibus_ack = 1'b1;
      @(negedge clk);
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      assert (ibus_cyc === 1'b0) else run_error("o_ibus_cyc stayed high after the ack");
      // Branches and JAL decide the next fetch address
      after_jump = (instr[6:0] == 7'b1100011) || (instr[6:0] == 7'b1101111);
      last_opcode = instr[6:0];
   endtask

   task automatic serve_data();
      word_t adr;
      word_t dat;
      word_t exp_adr;
      word_t exp_dat;
      logic  we;
      logic  exp_we;
      int    idx;
      int    delay;
      adr = dbus_adr;
      dat = dbus_dat;
      we  = dbus_we;
      // Only LW and SW access the data bus, once each
      assert (last_opcode == 7'b0000011 || last_opcode == 7'b0100011)
         else run_error("data bus request without a pending load or store");
      exp_we = (last_opcode == 7'b0100011);
      assert (we === exp_we) else value_mismatch("o_dbus_we", we, exp_we);
      assert (data_count > 0 || we === 1'b1)
         else run_error("data bus read seen before the first store");
      assert (adr >= DMEM_BASE && adr < DMEM_BASE + 4 * DMEM_WORDS)
         else run_error("data access outside the data memory");
      idx = (adr - DMEM_BASE) >> 2;
      if (we) begin
         assert (store_idx < store_count) else run_error("more stores than listed");
         exp_adr = input_words[STORE_IDX + 1 + 2 * store_idx];
         exp_dat = input_words[STORE_IDX + 2 + 2 * store_idx];
         assert (adr === exp_adr) else value_mismatch("o_dbus_adr", adr, exp_adr);
         assert (dat === exp_dat) else value_mismatch("o_dbus_dat", dat, exp_dat);
      end
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
         @(negedge clk);
         assert (dbus_cyc === 1'b1 && dbus_adr === adr && dbus_we === we && dbus_dat === dat)
            else run_error("data request dropped or changed before its ack");
      end
      if (we) begin
         dmem[idx] = dat;
      end else begin
         dbus_rdt = dmem[idx];
      end
      dbus_ack = 1'b1;
      @(negedge clk);
      dbus_ack = 1'b0;
      dbus_rdt = '0;
      assert (dbus_cyc === 1'b0) else run_error("o_dbus_cyc stayed high after the ack");
      if (we) begin
         store_idx++;
      end
      data_count++;
      last_opcode = '0;
   endtask

   initial begin
      clk         = 1'b0;
      arst_n      = 1'b0;
      ibus_rdt    = '0;
      ibus_ack    = 1'b0;
      dbus_rdt    = '0;
      dbus_ack    = 1'b0;
      seed        = 77;
      store_idx   = 0;
      fetch_idx   = 0;
      data_count  = 0;
      requests    = 0;
      after_jump  = 1'b0;
      last_opcode = '0;
      load_input();
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      // First fetch is already requested when reset ends
      assert (ibus_cyc === 1'b1) else run_error("no instruction request after reset");
      assert (ibus_adr === `CORE_RESET_PC)
         else value_mismatch("o_ibus_adr", ibus_adr, `CORE_RESET_PC);
      assert (dbus_cyc === 1'b0) else run_error("data bus request active after reset");
      while (store_idx < store_count) begin
         assert (requests < MAX_REQUESTS)
            else run_error("too many bus requests without reaching the last store");
         wait_for_request();
         if (ibus_cyc === 1'b1) begin
            serve_fetch();
         end else begin
            serve_data();
         end
         requests++;
      end
      assert (fetch_idx == fetch_count) else run_error("fewer branch targets fetched than listed");
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire
